//--- compile.f
+incdir+include
source/cce_msg_pkg.sv
source/mem_resp_forward.sv
source/inv_engine.sv
source/lce_cmd_merge.sv
source/cce_msg.sv
bench/tb_cce_msg.sv

//--- Makefile
# verilator build and run for the cce message unit
VERILATOR = verilator
VFLAGS    = --timing
TOP       = tb_cce_msg
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q -F '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- include/tb_checks.svh
// bench compare tasks

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// plain failure with a message in words
task automatic fail_msg(input string msg);
  $display("%s", msg);
  $display(">>> FAIL");
  $fatal(1, "test failed");
endtask

task automatic check_cmd(input string test, input lce_cmd_s exp, input lce_cmd_s act);
  if (act !== exp) begin
    $display("CHECK FAILED %s lce_cmd expected %h actual %h", test, exp, act);
    fail_msg("lce command mismatch");
  end
endtask

task automatic check_pending(input string test, input pending_w_s exp, input pending_w_s act);
  if (act !== exp) begin
    $display("CHECK FAILED %s pending_w expected %h actual %h", test, exp, act);
    fail_msg("pending write mismatch");
  end
endtask

task automatic check_dir(input string test, input dir_w_s exp, input dir_w_s act);
  if (act !== exp) begin
    $display("CHECK FAILED %s dir_w expected %h actual %h", test, exp, act);
    fail_msg("directory write mismatch");
  end
endtask

// single strobe compare where x counts as a mismatch
task automatic check_bit(input string test, input logic exp, input logic act);
  if (act !== exp) begin
    $display("CHECK FAILED %s expected %b actual %b", test, exp, act);
    fail_msg("strobe mismatch");
  end
endtask

`endif

//--- bench/tb_cce_msg.sv
// cce message unit testbench

`timescale 1ns/1ns

module tb_cce_msg
  import cce_msg_pkg::*;
  ();

  localparam int num_lce_lp = 8;
  localparam int cce_id_lp  = 2;
  // each test runs a few dozen cycles at most so this leaves a wide margin
  localparam int timeout_cycles = 2000;

  logic                                 clk;
  logic                                 reset;
  mem_resp_s                            mem_resp;
  logic                                 mem_resp_v;
  logic                                 mem_resp_yumi;
  lce_resp_s                            lce_resp;
  logic                                 lce_resp_v;
  logic                                 lce_resp_yumi;
  lce_cmd_s                             lce_cmd;
  logic                                 lce_cmd_v;
  logic                                 lce_cmd_ready;
  pending_w_s                           pending_w;
  logic                                 pending_w_v;
  dir_w_s                               dir_w;
  logic                                 dir_w_v;
  logic                                 inv_start;
  inv_req_s                             inv_req;
  logic [num_lce_lp-1:0]                sharers_hits;
  logic [num_lce_lp-1:0][way_width-1:0] sharers_ways;
  logic                                 busy;

  integer seed = 32'h1452b37b;
  int     cycles = 0;

  `include "tb_checks.svh"

  cce_msg #(
    .num_lce_p(num_lce_lp),
    .cce_id_p (cce_id_lp)
  ) u_dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .mem_resp_i     (mem_resp),
    .mem_resp_v_i   (mem_resp_v),
    .mem_resp_yumi_o(mem_resp_yumi),
    .lce_resp_i     (lce_resp),
    .lce_resp_v_i   (lce_resp_v),
    .lce_resp_yumi_o(lce_resp_yumi),
    .lce_cmd_o      (lce_cmd),
    .lce_cmd_v_o    (lce_cmd_v),
    .lce_cmd_ready_i(lce_cmd_ready),
    .pending_w_o    (pending_w),
    .pending_w_v_o  (pending_w_v),
    .dir_w_o        (dir_w),
    .dir_w_v_o      (dir_w_v),
    .inv_start_i    (inv_start),
    .inv_req_i      (inv_req),
    .sharers_hits_i (sharers_hits),
    .sharers_ways_i (sharers_ways),
    .busy_o         (busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles) begin
      fail_msg("timeout, the run did not finish within the cycle limit");
    end
  end

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // outputs are sampled mid cycle well clear of both edges
  task automatic settle();
    #10;
  endtask

  function automatic logic [paddr_width-1:0] rand_addr();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[paddr_width-1:0];
  endfunction

  function automatic logic [block_width-1:0] rand_block();
    logic [block_width-1:0] blk;
    for (int i = 0; i < block_width / 32; i++) begin
      blk[i*32 +: 32] = $random(seed);
    end
    return blk;
  endfunction

  function automatic mem_resp_s make_mem_resp(input mem_msg_type_e t);
    mem_resp_s r;
    r.msg_type = t;
    r.addr     = rand_addr();
    r.size     = size_width'($random(seed));
    r.lce_id   = lce_id_width'($random(seed));
    r.way_id   = way_width'($random(seed));
    r.state    = e_coh_e;
    r.data     = rand_block();
    return r;
  endfunction

  // expected lce command for a forwarded memory response
  function automatic lce_cmd_s expected_fwd(input mem_resp_s r);
    lce_cmd_s c;
    c        = '0;
    c.src_id = lce_id_width'(cce_id_lp);
    c.dst_id = r.lce_id;
    c.addr   = r.addr;
    if (r.msg_type == e_mem_uc_rd) begin
      c.msg_type = e_lce_cmd_uc_data;
      c.size     = r.size;
      c.data     = r.data;
    end else if (r.msg_type == e_mem_uc_wr) begin
      // store done carries nothing but the address
      c.msg_type = e_lce_cmd_uc_st_done;
    end else begin
      c.msg_type = e_lce_cmd_data;
      c.size     = r.size;
      c.way_id   = r.way_id;
      c.state    = r.state;
      c.data     = r.data;
    end
    return c;
  endfunction

  // one memory response accepted in the same cycle
  task automatic fwd_test(input string test, input mem_msg_type_e t);
    mem_resp_s r;
    logic      has_cmd;
    logic      has_pend;
    r          = make_mem_resp(t);
    has_cmd    = (t != e_mem_wr);
    has_pend   = (t == e_mem_rd) || (t == e_mem_wr);
    mem_resp   = r;
    mem_resp_v = 1'b1;
    settle();
    check_bit({test, " cmd_v"}, has_cmd, lce_cmd_v);
    if (has_cmd) begin
      check_cmd(test, expected_fwd(r), lce_cmd);
    end
    check_bit({test, " mem_yumi"}, 1'b1, mem_resp_yumi);
    check_bit({test, " pending_v"}, has_pend, pending_w_v);
    if (has_pend) begin
      check_pending(test, '{addr: r.addr, pending: 1'b0}, pending_w);
    end
    check_bit({test, " dir_v"}, 1'b0, dir_w_v);
    next_cycle();
    mem_resp_v = 1'b0;
  endtask

  // coh ack alone and then colliding with a writeback on the pending port
  task automatic coh_ack_test();
    logic [paddr_width-1:0] ack_addr;
    mem_resp_s              wb;
    ack_addr   = rand_addr();
    lce_resp   = '{msg_type: e_lce_resp_coh_ack, src_id: 4'd4, addr: ack_addr};
    lce_resp_v = 1'b1;
    settle();
    check_bit("coh_ack yumi", 1'b1, lce_resp_yumi);
    check_bit("coh_ack pending_v", 1'b1, pending_w_v);
    check_pending("coh_ack", '{addr: ack_addr, pending: 1'b0}, pending_w);
    next_cycle();
    wb         = make_mem_resp(e_mem_wr);
    mem_resp   = wb;
    mem_resp_v = 1'b1;
    settle();
    // writeback owns the port so the ack has to wait
    check_bit("coh_ack blocked yumi", 1'b0, lce_resp_yumi);
    check_bit("coh_ack blocked mem_yumi", 1'b1, mem_resp_yumi);
    check_pending("coh_ack blocked", '{addr: wb.addr, pending: 1'b0}, pending_w);
    next_cycle();
    mem_resp_v = 1'b0;
    settle();
    check_bit("coh_ack retry yumi", 1'b1, lce_resp_yumi);
    check_pending("coh_ack retry", '{addr: ack_addr, pending: 1'b0}, pending_w);
    next_cycle();
    lce_resp_v = 1'b0;
  endtask

  // cached read held off by ready low and then released
  task automatic backpressure_test();
    mem_resp_s r;
    r             = make_mem_resp(e_mem_rd);
    mem_resp      = r;
    mem_resp_v    = 1'b1;
    lce_cmd_ready = 1'b0;
    repeat (3) begin
      settle();
      check_bit("stall cmd_v", 1'b0, lce_cmd_v);
      check_bit("stall mem_yumi", 1'b0, mem_resp_yumi);
      check_bit("stall pending_v", 1'b0, pending_w_v);
      next_cycle();
    end
    lce_cmd_ready = 1'b1;
    settle();
    check_bit("release cmd_v", 1'b1, lce_cmd_v);
    check_cmd("release", expected_fwd(r), lce_cmd);
    check_bit("release mem_yumi", 1'b1, mem_resp_yumi);
    check_bit("release pending_v", 1'b1, pending_w_v);
    check_pending("release", '{addr: r.addr, pending: 1'b0}, pending_w);
    next_cycle();
    mem_resp_v = 1'b0;
  endtask

  // one-cycle start pulse with fresh random ways
  task automatic start_inv(input inv_req_s req, input logic [num_lce_lp-1:0] hits);
    for (int i = 0; i < num_lce_lp; i++) begin
      sharers_ways[i] = way_width'($random(seed));
    end
    inv_req      = req;
    sharers_hits = hits;
    inv_start    = 1'b1;
    next_cycle();
    inv_start = 1'b0;
  endtask

  // waits for the next invalidate and checks it with its directory write
  task automatic expect_inv(input string test, input int dst);
    int       waited;
    lce_cmd_s exp;
    dir_w_s   exp_d;
    exp          = '0;
    exp.msg_type = e_lce_cmd_inv;
    exp.src_id   = lce_id_width'(cce_id_lp);
    exp.dst_id   = lce_id_width'(dst);
    exp.addr     = inv_req.addr;
    exp.way_id   = sharers_ways[dst];
    exp_d        = '{addr: inv_req.addr, lce_id: lce_id_width'(dst),
                     way_id: sharers_ways[dst], state: e_coh_i};
    waited       = 0;
    settle();
    while (!lce_cmd_v) begin
      waited++;
      if (waited > 20) begin
        fail_msg({test, ": no invalidate came out within 20 cycles"});
      end
      next_cycle();
      settle();
    end
    check_cmd(test, exp, lce_cmd);
    check_bit({test, " dir_v"}, 1'b1, dir_w_v);
    check_dir(test, exp_d, dir_w);
    check_bit({test, " busy"}, 1'b1, busy);
    next_cycle();
  endtask

  task automatic send_inv_ack(input string test, input int src);
    lce_resp   = '{msg_type: e_lce_resp_inv_ack, src_id: lce_id_width'(src),
                   addr: inv_req.addr};
    lce_resp_v = 1'b1;
    settle();
    // engine still busy while this ack is outstanding
    check_bit({test, " ack busy"}, 1'b1, busy);
    check_bit({test, " ack yumi"}, 1'b1, lce_resp_yumi);
    check_bit({test, " ack pending_v"}, 1'b0, pending_w_v);
    next_cycle();
    lce_resp_v = 1'b0;
  endtask

  // busy must fall and no command may go out meanwhile
  task automatic wait_idle(input string test);
    int waited;
    waited = 0;
    settle();
    while (busy) begin
      check_bit({test, " idle cmd_v"}, 1'b0, lce_cmd_v);
      waited++;
      if (waited > 20) begin
        fail_msg({test, ": engine stayed busy for more than 20 cycles"});
      end
      next_cycle();
      settle();
    end
    next_cycle();
  endtask

  task automatic inv_test();
    inv_req_s req;
    req = '{addr: rand_addr(), req_lce: 4'd3, owner_lce: 4'd6, owner_v: 1'b1};
    // sharers 1, 3, 5, 6 leave only 1 and 5
    start_inv(req, 8'b0110_1010);
    expect_inv("inv first", 1);
    expect_inv("inv second", 5);
    settle();
    check_bit("inv sends done", 1'b0, lce_cmd_v);
    check_bit("inv busy", 1'b1, busy);
    next_cycle();
    send_inv_ack("inv", 1);
    send_inv_ack("inv", 5);
    wait_idle("inv");
    // requester and owner only leave nothing to send
    start_inv(req, 8'b0100_1000);
    settle();
    check_bit("inv empty busy", 1'b1, busy);
    wait_idle("inv empty");
    // owner without the flag still gets an invalidate
    req.owner_v = 1'b0;
    start_inv(req, 8'b0100_1000);
    expect_inv("inv owner", 6);
    send_inv_ack("inv owner", 6);
    wait_idle("inv owner");
  endtask

  task automatic arbitration_test();
    inv_req_s  req;
    mem_resp_s r;
    req = '{addr: rand_addr(), req_lce: 4'd3, owner_lce: 4'd6, owner_v: 1'b1};
    start_inv(req, 8'b0110_1010);
    r          = make_mem_resp(e_mem_rd);
    mem_resp   = r;
    mem_resp_v = 1'b1;
    settle();
    // forwarded data wins the port over the pending invalidate
    check_bit("arb fwd cmd_v", 1'b1, lce_cmd_v);
    check_cmd("arb fwd", expected_fwd(r), lce_cmd);
    check_bit("arb fwd dir_v", 1'b0, dir_w_v);
    check_pending("arb fwd", '{addr: r.addr, pending: 1'b0}, pending_w);
    next_cycle();
    mem_resp_v = 1'b0;
    expect_inv("arb first", 1);
    expect_inv("arb second", 5);
    send_inv_ack("arb", 5);
    send_inv_ack("arb", 1);
    wait_idle("arb");
  endtask

  initial begin
    reset         = 1'b1;
    mem_resp      = '0;
    mem_resp_v    = 1'b0;
    lce_resp      = '0;
    lce_resp_v    = 1'b0;
    lce_cmd_ready = 1'b1;
    inv_start     = 1'b0;
    inv_req       = '0;
    sharers_hits  = '0;
    sharers_ways  = '0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    settle();
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset cmd_v", 1'b0, lce_cmd_v);
    check_bit("reset pending_v", 1'b0, pending_w_v);
    check_bit("reset dir_v", 1'b0, dir_w_v);
    check_bit("reset mem_yumi", 1'b0, mem_resp_yumi);
    check_bit("reset lce_yumi", 1'b0, lce_resp_yumi);
    next_cycle();
    fwd_test("uc_rd", e_mem_uc_rd);
    fwd_test("uc_wr", e_mem_uc_wr);
    fwd_test("rd", e_mem_rd);
    fwd_test("wr", e_mem_wr);
    coh_ack_test();
    inv_test();
    backpressure_test();
    arbitration_test();
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- source/cce_msg.sv
// cce message unit top level

`timescale 1ns/1ns

module cce_msg
  import cce_msg_pkg::*;
  #(parameter int num_lce_p = 8,
    parameter int cce_id_p  = 0)
  (input  logic                                clk_i,
   input  logic                                reset_i,
   // memory responses
   input  mem_resp_s                           mem_resp_i,
   input  logic                                mem_resp_v_i,
   output logic                                mem_resp_yumi_o,
   // lce responses
   input  lce_resp_s                           lce_resp_i,
   input  logic                                lce_resp_v_i,
   output logic                                lce_resp_yumi_o,
   // lce commands with valid only raised alongside ready
   output lce_cmd_s                            lce_cmd_o,
   output logic                                lce_cmd_v_o,
   input  logic                                lce_cmd_ready_i,
   // pending bit and directory writes
   output pending_w_s                          pending_w_o,
   output logic                                pending_w_v_o,
   output dir_w_s                              dir_w_o,
   output logic                                dir_w_v_o,
   // invalidation start pulse
   input  logic                                inv_start_i,
   input  inv_req_s                            inv_req_i,
   input  logic [num_lce_p-1:0]                sharers_hits_i,
   input  logic [num_lce_p-1:0][way_width-1:0] sharers_ways_i,
   output logic                                busy_o);

  lce_cmd_s fwd_cmd;
  logic     fwd_cmd_v;
  logic     fwd_cmd_ready;
  lce_cmd_s inv_cmd;
  logic     inv_cmd_v;
  logic     inv_cmd_ready;
  logic     coh_ack_yumi;
  logic     inv_ack_yumi;

  // auto-forward of memory responses and coherence acks
  mem_resp_forward #(
    .cce_id_p(cce_id_p)
  ) u_fwd (
    .mem_resp_i     (mem_resp_i),
    .mem_resp_v_i   (mem_resp_v_i),
    .lce_resp_i     (lce_resp_i),
    .lce_resp_v_i   (lce_resp_v_i),
    .cmd_ready_i    (fwd_cmd_ready),
    .mem_resp_yumi_o(mem_resp_yumi_o),
    .coh_ack_yumi_o (coh_ack_yumi),
    .cmd_o          (fwd_cmd),
    .cmd_v_o        (fwd_cmd_v),
    .pending_w_o    (pending_w_o),
    .pending_w_v_o  (pending_w_v_o)
  );

  // invalidation routine
  inv_engine #(
    .num_lce_p(num_lce_p),
    .cce_id_p (cce_id_p)
  ) u_inv (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .inv_start_i   (inv_start_i),
    .inv_req_i     (inv_req_i),
    .sharers_hits_i(sharers_hits_i),
    .sharers_ways_i(sharers_ways_i),
    .cmd_ready_i   (inv_cmd_ready),
    .lce_resp_i    (lce_resp_i),
    .lce_resp_v_i  (lce_resp_v_i),
    .cmd_o         (inv_cmd),
    .cmd_v_o       (inv_cmd_v),
    .dir_w_o       (dir_w_o),
    .dir_w_v_o     (dir_w_v_o),
    .inv_ack_yumi_o(inv_ack_yumi),
    .busy_o        (busy_o)
  );

  lce_cmd_merge u_merge (
    .fwd_cmd_i      (fwd_cmd),
    .fwd_cmd_v_i    (fwd_cmd_v),
    .inv_cmd_i      (inv_cmd),
    .inv_cmd_v_i    (inv_cmd_v),
    .lce_cmd_ready_i(lce_cmd_ready_i),
    .coh_ack_yumi_i (coh_ack_yumi),
    .inv_ack_yumi_i (inv_ack_yumi),
    .fwd_cmd_ready_o(fwd_cmd_ready),
    .inv_cmd_ready_o(inv_cmd_ready),
    .lce_cmd_o      (lce_cmd_o),
    .lce_cmd_v_o    (lce_cmd_v_o),
    .lce_resp_yumi_o(lce_resp_yumi_o)
  );

endmodule

//--- source/lce_cmd_merge.sv
// lce command port merge

`timescale 1ns/1ns

module lce_cmd_merge
  import cce_msg_pkg::*;
  (input  lce_cmd_s fwd_cmd_i,
   input  logic     fwd_cmd_v_i,
   input  lce_cmd_s inv_cmd_i,
   input  logic     inv_cmd_v_i,
   input  logic     lce_cmd_ready_i,
   input  logic     coh_ack_yumi_i,
   input  logic     inv_ack_yumi_i,
   output logic     fwd_cmd_ready_o,
   output logic     inv_cmd_ready_o,
   output lce_cmd_s lce_cmd_o,
   output logic     lce_cmd_v_o,
   output logic     lce_resp_yumi_o);

  logic grant_fwd;
  logic grant_inv;

  // forwarding always wins and invalidates take the leftover cycles
  assign grant_fwd = fwd_cmd_v_i;
  assign grant_inv = ~fwd_cmd_v_i & inv_cmd_v_i;

  // each side only sees ready while it holds the grant
  assign fwd_cmd_ready_o = lce_cmd_ready_i & grant_fwd;
  assign inv_cmd_ready_o = lce_cmd_ready_i & grant_inv;

  always_comb begin
    if (grant_fwd) begin
      lce_cmd_o = fwd_cmd_i;
    end else begin
      lce_cmd_o = inv_cmd_i;
    end
  end

  // ready->valid on the port
  assign lce_cmd_v_o = lce_cmd_ready_i & (grant_fwd | grant_inv);

  // the two sides pop disjoint response types
  // so at most one of these is high in a cycle
  assign lce_resp_yumi_o = coh_ack_yumi_i | inv_ack_yumi_i;

endmodule

//--- source/inv_engine.sv
// invalidation engine

`timescale 1ns/1ns

module inv_engine
  import cce_msg_pkg::*;
  #(parameter int num_lce_p = 8,
    parameter int cce_id_p  = 0)
  (input  logic                                clk_i,
   input  logic                                reset_i,
   input  logic                                inv_start_i,
   input  inv_req_s                            inv_req_i,
   input  logic [num_lce_p-1:0]                sharers_hits_i,
   input  logic [num_lce_p-1:0][way_width-1:0] sharers_ways_i,
   input  logic                                cmd_ready_i,
   input  lce_resp_s                           lce_resp_i,
   input  logic                                lce_resp_v_i,
   output lce_cmd_s                            cmd_o,
   output logic                                cmd_v_o,
   output dir_w_s                              dir_w_o,
   output logic                                dir_w_v_o,
   output logic                                inv_ack_yumi_o,
   output logic                                busy_o);

  localparam int lg_num_lce_lp = (num_lce_p > 1) ? $clog2(num_lce_p) : 1;
  localparam int cnt_width_lp  = $clog2(num_lce_p + 1);

  typedef enum logic [1:0] {
    e_inv_idle,
    e_inv_send,
    e_inv_wait
  } inv_state_e;

  inv_state_e                          state_r, state_n;
  logic [num_lce_p-1:0]                sharers_r, sharers_n;
  logic [num_lce_p-1:0][way_width-1:0] ways_r;
  logic [paddr_width-1:0]              addr_r;
  logic [cnt_width_lp-1:0]             cnt_r, cnt_n;

  logic [num_lce_p-1:0]     req_oh;
  logic [num_lce_p-1:0]     owner_oh;
  logic [num_lce_p-1:0]     start_mask;
  logic [num_lce_p-1:0]     pe_oh;
  logic [lg_num_lce_lp-1:0] pe_id;
  logic                     pe_v;
  logic                     sent;
  logic                     ack;

  // requester never gets an inv and the owner is only skipped when flagged
  assign req_oh     = num_lce_p'(1) << inv_req_i.req_lce;
  assign owner_oh   = inv_req_i.owner_v ? (num_lce_p'(1) << inv_req_i.owner_lce) : '0;
  assign start_mask = sharers_hits_i & ~req_oh & ~owner_oh;

  // lowest remaining sharer wins
  always_comb begin
    pe_id = '0;
    pe_v  = 1'b0;
    for (int i = num_lce_p - 1; i >= 0; i--) begin
      if (sharers_r[i]) begin
        pe_id = lg_num_lce_lp'(i);
        pe_v  = 1'b1;
      end
    end
  end
  assign pe_oh = num_lce_p'(1) << pe_id;

  assign busy_o  = (state_r != e_inv_idle);
  assign cmd_v_o = (state_r == e_inv_send) && pe_v;
  assign sent    = cmd_v_o && cmd_ready_i;
  // inv acks drain whenever the routine is running
  assign ack            = busy_o && lce_resp_v_i && (lce_resp_i.msg_type == e_lce_resp_inv_ack);
  assign inv_ack_yumi_o = ack;

  // outstanding acks go up on each send and down on each ack
  assign cnt_n = cnt_r + cnt_width_lp'(sent) - cnt_width_lp'(ack);

  always_comb begin
    cmd_o          = '0;
    cmd_o.msg_type = e_lce_cmd_inv;
    cmd_o.src_id   = lce_id_width'(cce_id_p);
    cmd_o.dst_id   = lce_id_width'(pe_id);
    cmd_o.addr     = addr_r;
    cmd_o.way_id   = ways_r[pe_id];

    // directory entry goes to invalid with each accepted inv
    dir_w_v_o      = sent;
    dir_w_o.addr   = addr_r;
    dir_w_o.lce_id = lce_id_width'(pe_id);
    dir_w_o.way_id = ways_r[pe_id];
    dir_w_o.state  = e_coh_i;
  end

  always_comb begin
    state_n   = state_r;
    sharers_n = sharers_r;
    unique case (state_r)
      e_inv_idle: begin
        if (inv_start_i) begin
          sharers_n = start_mask;
          state_n   = (start_mask == '0) ? e_inv_wait : e_inv_send;
        end
      end
      e_inv_send: begin
        if (sent) begin
          sharers_n = sharers_r & ~pe_oh;
          if (sharers_n == '0) begin
            state_n = e_inv_wait;
          end
        end
      end
      e_inv_wait: begin
        if (cnt_n == '0) begin
          state_n = e_inv_idle;
        end
      end
      default: state_n = e_inv_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= e_inv_idle;
      sharers_r <= '0;
      cnt_r     <= '0;
    end else begin
      state_r   <= state_n;
      sharers_r <= sharers_n;
      cnt_r     <= cnt_n;
    end
  end

  // captured line and ways for the whole routine
  always_ff @(posedge clk_i) begin
    if ((state_r == e_inv_idle) && inv_start_i) begin
      ways_r <= sharers_ways_i;
      addr_r <= inv_req_i.addr;
    end
  end

endmodule

//--- source/mem_resp_forward.sv
// memory response forwarder

`timescale 1ns/1ns

module mem_resp_forward
  import cce_msg_pkg::*;
  #(parameter int cce_id_p = 0)
  (input  mem_resp_s  mem_resp_i,
   input  logic       mem_resp_v_i,
   input  lce_resp_s  lce_resp_i,
   input  logic       lce_resp_v_i,
   // ready is already gated by the command port grant
   input  logic       cmd_ready_i,
   output logic       mem_resp_yumi_o,
   output logic       coh_ack_yumi_o,
   output lce_cmd_s   cmd_o,
   output logic       cmd_v_o,
   output pending_w_s pending_w_o,
   output logic       pending_w_v_o);

  // set when the memory response owns the pending write port this cycle
  logic mem_pend_w;

  always_comb begin
    cmd_o           = '0;
    cmd_v_o         = 1'b0;
    mem_resp_yumi_o = 1'b0;
    coh_ack_yumi_o  = 1'b0;
    pending_w_o     = '0;
    pending_w_v_o   = 1'b0;
    mem_pend_w      = 1'b0;

    // fields common to every forwarded command
    cmd_o.src_id = lce_id_width'(cce_id_p);
    cmd_o.dst_id = mem_resp_i.lce_id;
    cmd_o.addr   = mem_resp_i.addr;

    if (mem_resp_v_i) begin
      unique case (mem_resp_i.msg_type)
        e_mem_uc_rd: begin
          // uncached load data goes straight back without a pending bit
          cmd_o.msg_type  = e_lce_cmd_uc_data;
          cmd_o.size      = mem_resp_i.size;
          cmd_o.data      = mem_resp_i.data;
          cmd_v_o         = 1'b1;
          mem_resp_yumi_o = cmd_ready_i;
        end
        e_mem_uc_wr: begin
          // store done carries no data and size stays zero
          cmd_o.msg_type  = e_lce_cmd_uc_st_done;
          cmd_v_o         = 1'b1;
          mem_resp_yumi_o = cmd_ready_i;
        end
        e_mem_rd: begin
          cmd_o.msg_type  = e_lce_cmd_data;
          cmd_o.size      = mem_resp_i.size;
          cmd_o.way_id    = mem_resp_i.way_id;
          cmd_o.state     = mem_resp_i.state;
          cmd_o.data      = mem_resp_i.data;
          cmd_v_o         = 1'b1;
          mem_resp_yumi_o = cmd_ready_i;
          // pending clear only once the data command is accepted
          mem_pend_w      = cmd_ready_i;
        end
        e_mem_wr: begin
          // writeback ack needs no lce command
          mem_resp_yumi_o = 1'b1;
          mem_pend_w      = 1'b1;
        end
        default: begin
        end
      endcase
    end

    if (mem_pend_w) begin
      pending_w_v_o    = 1'b1;
      pending_w_o.addr = mem_resp_i.addr;
    end else if (lce_resp_v_i && (lce_resp_i.msg_type == e_lce_resp_coh_ack)) begin
      // coh ack only gets the port when memory left it free
      coh_ack_yumi_o   = 1'b1;
      pending_w_v_o    = 1'b1;
      pending_w_o.addr = lce_resp_i.addr;
    end
  end

endmodule

//--- source/cce_msg_pkg.sv
// cce message unit
// shared widths, opcodes and message structs

package cce_msg_pkg;

  localparam int paddr_width  = 40;
  localparam int block_width  = 512;
  // lce ids are 4 bits wide so at most 16 lces
  localparam int lce_id_width = 4;
  localparam int way_width    = 3;
  localparam int size_width   = 3;

  typedef enum logic [2:0] {
    e_coh_i = 3'd0,
    e_coh_s = 3'd1,
    e_coh_e = 3'd2,
    e_coh_m = 3'd3,
    e_coh_o = 3'd4,
    e_coh_f = 3'd5
  } coh_state_e;

  // only inv, data, uc_data and uc_st_done are issued by this unit
  typedef enum logic [3:0] {
    e_lce_cmd_sync       = 4'd0,
    e_lce_cmd_set_clear  = 4'd1,
    e_lce_cmd_transfer   = 4'd2,
    e_lce_cmd_writeback  = 4'd3,
    e_lce_cmd_set_tag    = 4'd4,
    e_lce_cmd_inv        = 4'd6,
    e_lce_cmd_data       = 4'd7,
    e_lce_cmd_uc_data    = 4'd8,
    e_lce_cmd_uc_st_done = 4'd9
  } lce_cmd_type_e;

  typedef enum logic [3:0] {
    e_mem_rd    = 4'd0,
    e_mem_wr    = 4'd1,
    e_mem_uc_rd = 4'd2,
    e_mem_uc_wr = 4'd3
  } mem_msg_type_e;

  typedef enum logic [1:0] {
    e_lce_resp_coh_ack = 2'd0,
    e_lce_resp_inv_ack = 2'd1
  } lce_resp_type_e;

  // lce id and way of a memory response name the requester's target line
  typedef struct packed {
    mem_msg_type_e           msg_type;
    logic [paddr_width-1:0]  addr;
    logic [size_width-1:0]   size;
    logic [lce_id_width-1:0] lce_id;
    logic [way_width-1:0]    way_id;
    coh_state_e              state;
    logic [block_width-1:0]  data;
  } mem_resp_s;

  typedef struct packed {
    lce_resp_type_e          msg_type;
    logic [lce_id_width-1:0] src_id;
    logic [paddr_width-1:0]  addr;
  } lce_resp_s;

  typedef struct packed {
    lce_cmd_type_e           msg_type;
    logic [lce_id_width-1:0] src_id;
    logic [lce_id_width-1:0] dst_id;
    logic [paddr_width-1:0]  addr;
    logic [size_width-1:0]   size;
    logic [way_width-1:0]    way_id;
    coh_state_e              state;
    logic [block_width-1:0]  data;
  } lce_cmd_s;

  typedef struct packed {
    logic [paddr_width-1:0] addr;
    logic                   pending;
  } pending_w_s;

  typedef struct packed {
    logic [paddr_width-1:0]  addr;
    logic [lce_id_width-1:0] lce_id;
    logic [way_width-1:0]    way_id;
    coh_state_e              state;
  } dir_w_s;

  typedef struct packed {
    logic [paddr_width-1:0]  addr;
    logic [lce_id_width-1:0] req_lce;
    logic [lce_id_width-1:0] owner_lce;
    logic                    owner_v;
  } inv_req_s;

endpackage
